// File: Makefile
# verilator flow for the life engine

TOOL       = verilator
FLAGS      = --timing
LINT_FLAGS = --lint-only
TOP        = tb_life_engine
RTL_TOP    = life_engine
FILELIST   = filelist.f
OBJ_DIR    = obj_dir
LOG        = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) $(LINT_FLAGS) $(FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(TOOL) --binary $(FLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(OBJ_DIR) -o $(TOP)
	./$(OBJ_DIR)/$(TOP) | tee $(LOG)
	@if grep -q "^NO ERRORS$$" $(LOG); then \
		echo "PASS"; \
	else \
		echo "FAIL"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: design/gen_stage.sv
// one life generation over a streaming three-row window
// registered vertical tallies, horizontally wrapping 3x3 count, life rule

`timescale 1ns/1ps

`include "life_defines.svh"

module gen_stage
	import life_cell_pkg::*;
(
	input  logic clk,
	input  logic arst_n,
	input  logic shift,		// aligned shift enable, shared by all stages
	input  row_t row_in,	// newest row of the stream
	output row_t row_out	// next gen of the centre row
);

	//////////////////////////////////////////////////////////////////////
	// window and tallies
	//////////////////////////////////////////////////////////////////////

	// win[0] newest, win[2] oldest
	row_t win [3];

	// per-column sums of the window as it was before the last shift
	tally3_t [`LIFE_WIDTH-1:0] tally_q;
	tally3_t [`LIFE_WIDTH-1:0] tally;

	// vertical 3-sum of the current window
	always_comb begin
		for (int col = 0; col < `LIFE_WIDTH; col++) begin
			tally[col] = {1'b0, win[0][col]} +
				{1'b0, win[1][col]} +
				{1'b0, win[2][col]};
		end
	end

	// everything moves on shift only, holds otherwise
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			win[0]  <= '0;
			win[1]  <= '0;
			win[2]  <= '0;
			tally_q <= '0;
		end else if (shift) begin
			win[0]  <= row_in;
			win[1]  <= win[0];
			win[2]  <= win[1];
			tally_q <= tally;	// old window, its centre is now win[2]
		end
	end

	//////////////////////////////////////////////////////////////////////
	// neighbourhood count and rule
	//////////////////////////////////////////////////////////////////////

	count9_t count [`LIFE_WIDTH];

	// horizontal 3-sum of tallies, wraps col 0 <-> col width-1
	always_comb begin
		int lft;
		int rgt;
		for (int col = 0; col < `LIFE_WIDTH; col++) begin
			lft = (col == 0) ? `LIFE_WIDTH - 1 : col - 1;	// left wrap
			rgt = (col == `LIFE_WIDTH - 1) ? 0 : col + 1;	// right wrap
			count[col] = {2'b00, tally_q[lft]} +
				{2'b00, tally_q[col]} +
				{2'b00, tally_q[rgt]};
		end
	end

	// count includes the centre cell
	// 3 -> born or survives with 2 neighbours
	// 4 -> survives with 3 neighbours if alive
	always_comb begin
		for (int col = 0; col < `LIFE_WIDTH; col++) begin
			row_out[col] = (count[col] == 4'd3) ||
				((count[col] == 4'd4) && win[2][col]);	// centre = oldest row
		end
	end

endmodule

// File: design/life_cell_pkg.sv
// cell array types
// one row of cells, per-column vertical tallies, 3x3 neighbourhood counts

`include "life_defines.svh"

package life_cell_pkg;

	// one row, bit n is column n, 1 = alive
	typedef logic [`LIFE_WIDTH-1:0] row_t;

	// vertical sum of 3 cells in a column, 0..3
	typedef logic [1:0] tally3_t;

	// 3x3 sum incl centre, 0..9
	typedef logic [3:0] count9_t;

endpackage

// File: design/life_core.sv
// life pipeline core
// sh alignment to the ram read latency, chain of gen stages, write row reg

`timescale 1ns/1ps

`include "life_defines.svh"

module life_core
	import life_cell_pkg::*;
#(
	parameter int gens = `LIFE_GENS	// generations per pass, 1 or more
) (
	input  logic clk,
	input  logic arst_n,
	input  logic sh,		// shift strobe, sampled with raddr
	input  row_t rd_row,	// row from the ram read port
	output row_t wr_row		// final gen row, ram write data
);

	logic [1:0] sh_del;	// matches 2 cycle ram read
	logic       shift;	// global enable
	row_t       stage_in  [gens];
	row_t       stage_out [gens];

	// sh delay line
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			sh_del <= '0;
		end else begin
			sh_del <= {sh_del[0], sh};
		end
	end

	assign shift = sh_del[1];	// acts at 3rd edge after sh sample

	//////////////////////////////////////////////////////////////////////
	// stage chain
	//////////////////////////////////////////////////////////////////////

	for (genvar g = 0; g < gens; g++) begin : g_stage
		if (g == 0) begin : g_first
			assign stage_in[g] = rd_row;		// straight from ram
		end else begin : g_next
			assign stage_in[g] = stage_out[g-1];	// prev gen, 1 position boundary lag
		end

		gen_stage stage0 (
			.clk     (clk),
			.arst_n  (arst_n),
			.shift   (shift),
			.row_in  (stage_in[g]),
			.row_out (stage_out[g])
		);
	end

	// output reg, lag is 3 positions per gen in total
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wr_row <= '0;
		end else if (shift) begin
			wr_row <= stage_out[gens-1];
		end
	end

	// strobes closer than 3 cycles would drop or merge a shift
	sh_spacing: assert property (@(posedge clk) disable iff (!arst_n)
		sh |-> (sh_del == 2'b00))
		else $error("life_core: sh while delay line busy");

endmodule

// File: design/life_engine.sv
// life engine top level
// row ram, life core, init write mux, ld read port latching one row

`timescale 1ns/1ps

`include "life_defines.svh"

module life_engine
	import life_cell_pkg::*;
(
	input  logic                       clk,
	input  logic                       arst_n,
	// memory control, host sequences all addresses
	input  logic [`LIFE_ADDR_BITS-1:0] raddr,	// also the ld read address
	input  logic [`LIFE_ADDR_BITS-1:0] waddr,
	input  logic                       we,
	// pipeline shift
	input  logic                       sh,
	// read port
	input  logic                       ld,
	// init write port
	input  logic                       init,
	input  logic [`LIFE_WIDTH-1:0]     init_data,
	output logic [`LIFE_WIDTH-1:0]     dout		// latched row
);

	row_mem_if mem_bus ();	// engine drives the host side

	row_t       wr_row;	// core result
	logic [1:0] ld_del;	// matches 2 cycle ram read

	//////////////////////////////////////////////////////////////////////
	// memory
	//////////////////////////////////////////////////////////////////////

	assign mem_bus.raddr = raddr;
	assign mem_bus.waddr = waddr;
	assign mem_bus.we    = we;
	assign mem_bus.wdata = init ? init_data : wr_row;	// init wins over core

	row_ram ram0 (
		.clk    (clk),
		.arst_n (arst_n),
		.mem    (mem_bus)
	);

	//////////////////////////////////////////////////////////////////////
	// life pipeline
	//////////////////////////////////////////////////////////////////////

	life_core #(
		.gens (`LIFE_GENS)
	) core0 (
		.clk    (clk),
		.arst_n (arst_n),
		.sh     (sh),
		.rd_row (mem_bus.rdata),
		.wr_row (wr_row)
	);

	//////////////////////////////////////////////////////////////////////
	// read port
	//////////////////////////////////////////////////////////////////////

	// dout loads at the 3rd edge after ld, holds until next ld
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			ld_del <= '0;
			dout   <= '0;
		end else begin
			ld_del <= {ld_del[0], ld};
			if (ld_del[1]) begin
				dout <= mem_bus.rdata;	// latch one row
			end
		end
	end

endmodule

// File: design/life_mem_pkg.sv
// row memory types

`include "life_defines.svh"

package life_mem_pkg;

	// ram row address
	// low half and high half used as the two image buffers
	typedef logic [`LIFE_ADDR_BITS-1:0] row_addr_t;

endpackage

// File: design/row_mem_if.sv
// row ram port bundle, read and write side
// host modport for the engine top, ram modport for the memory

`timescale 1ns/1ps

interface row_mem_if
	import life_cell_pkg::*, life_mem_pkg::*;
();

	row_addr_t raddr;	// read row address
	row_addr_t waddr;	// write row address
	logic      we;		// write strobe
	row_t      wdata;	// write row
	row_t      rdata;	// registered read row

	// engine side
	modport host (output raddr, output waddr, output we, output wdata, input rdata);

	// memory side
	modport ram (input raddr, input waddr, input we, input wdata, output rdata);

endinterface

// File: design/row_ram.sv
// two-port row memory
// registered read address and registered read row, 2 cycle read latency

`timescale 1ns/1ps

`include "life_defines.svh"

module row_ram
	import life_cell_pkg::*, life_mem_pkg::*;
(
	input  logic clk,
	input  logic arst_n,
	row_mem_if.ram mem
);

	row_t      ram [`LIFE_DEPTH];	// storage, no reset
	row_addr_t raddr_q;				// read address reg

	// write port, one row per we
	always_ff @(posedge clk) begin
		if (mem.we) begin
			ram[mem.waddr] <= mem.wdata;
		end
	end

	// read pipe
	// edge 1 captures the address, edge 2 puts the row on rdata
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			raddr_q   <= '0;
			mem.rdata <= '0;
		end else begin
			raddr_q   <= mem.raddr;
			mem.rdata <= ram[raddr_q];	// read-before-write on same row
		end
	end

	// an unknown we from the host would corrupt a random row
	we_known: assert property (@(posedge clk) disable iff (!arst_n)
		!$isunknown(mem.we))
		else $error("row_ram: we unknown");

endmodule

// File: filelist.f
+incdir+include
design/life_cell_pkg.sv
design/life_mem_pkg.sv
design/row_mem_if.sv
design/row_ram.sv
design/gen_stage.sv
design/life_core.sv
design/life_engine.sv
verification/life_model_pkg.sv
verification/tb_life_engine.sv

// File: include/life_defines.svh
// sizing macros for the row-streaming life engine
// row width, ram depth, row address bits, generations per pass

`ifndef LIFE_DEFINES_SVH
`define LIFE_DEFINES_SVH

// columns per row, also the datapath width
`define LIFE_WIDTH 16

// rows held in the row ram, two halves of 16 for double buffering
`define LIFE_DEPTH 32

// row address width, log2 of depth
`define LIFE_ADDR_BITS 5

// generation stages chained per pass
`define LIFE_GENS 2

`endif

// File: verification/life_model_pkg.sv
// life reference model for the testbench
// toroidal image, one life step, stream order, image builders

`include "life_defines.svh"

package life_model_pkg;

	localparam int img_rows = 16;			// image height, one ram half
	localparam int img_cols = `LIFE_WIDTH;

	typedef logic [`LIFE_WIDTH-1:0] img_row_t;
	typedef logic [img_rows-1:0][`LIFE_WIDTH-1:0] image_t;	// img[row][col]

	// index modulo n, also for negative values
	function automatic int wrap(int v, int n);
		return ((v % n) + n) % n;
	endfunction

	// cell on the torus
	function automatic logic cell_at(image_t img, int r, int c);
		return img[wrap(r, img_rows)][wrap(c, img_cols)];
	endfunction

	// one generation, neighbour count without the centre
	function automatic image_t step(image_t img);
		image_t nxt;
		int     n;
		for (int r = 0; r < img_rows; r++) begin
			for (int c = 0; c < img_cols; c++) begin
				n = 0;
				for (int dr = -1; dr <= 1; dr++) begin
					for (int dc = -1; dc <= 1; dc++) begin
						if (dr != 0 || dc != 0) begin
							n += int'(cell_at(img, r + dr, c + dc));
						end
					end
				end
				nxt[r][c] = (n == 3) || (n == 2 && img[r][c]);	// birth or survival
			end
		end
		return nxt;
	endfunction

	// n generations in a row
	function automatic image_t evolve(image_t img, int n);
		image_t cur;
		cur = img;
		for (int i = 0; i < n; i++) begin
			cur = step(cur);
		end
		return cur;
	endfunction

	// image row at stream position p, gens rows of lead-in
	function automatic int stream_row(int p, int gens);
		return wrap(p - gens, img_rows);
	endfunction

	// each cell alive with pct percent chance
	function automatic image_t random_image(int pct);
		image_t img;
		for (int r = 0; r < img_rows; r++) begin
			for (int c = 0; c < img_cols; c++) begin
				img[r][c] = ($urandom % 100) < pct;
			end
		end
		return img;
	endfunction

	function automatic image_t set_cell(image_t img, int r, int c);
		image_t res;
		res = img;
		res[wrap(r, img_rows)][wrap(c, img_cols)] = 1'b1;
		return res;
	endfunction

	// blinkers and a glider sitting on the seams of the torus
	function automatic image_t edge_image();
		image_t img;
		img = '0;
		img = set_cell(img, 5, 15);		// horizontal blinker, col seam
		img = set_cell(img, 5, 0);
		img = set_cell(img, 5, 1);
		img = set_cell(img, 15, 8);		// vertical blinker, row seam
		img = set_cell(img, 0, 8);
		img = set_cell(img, 1, 8);
		img = set_cell(img, 14, 15);	// glider over the corner
		img = set_cell(img, 15, 16);
		img = set_cell(img, 16, 14);
		img = set_cell(img, 16, 15);
		img = set_cell(img, 16, 16);
		return img;
	endfunction

endpackage

// File: verification/tb_life_engine.sv
// testbench for the life engine
// random and seam images through one or more passes, checked against the model

`timescale 1ns/1ps

`include "life_defines.svh"

module tb_life_engine
	import life_model_pkg::*;
();

	localparam int gens       = `LIFE_GENS;
	localparam int half_a     = 0;			// first image buffer
	localparam int half_b     = img_rows;	// second image buffer
	localparam int seed       = 39593;
	localparam int max_cycles = 20000;		// watchdog limit
	localparam int passes     = 4;

	logic                       clk;
	logic                       arst_n;
	logic [`LIFE_ADDR_BITS-1:0] raddr;
	logic [`LIFE_ADDR_BITS-1:0] waddr;
	logic                       we;
	logic                       sh;
	logic                       ld;
	logic                       init;
	logic [`LIFE_WIDTH-1:0]     init_data;
	logic [`LIFE_WIDTH-1:0]     dout;

	int cycles;

	life_engine dut0 (
		.clk       (clk),
		.arst_n    (arst_n),
		.raddr     (raddr),
		.waddr     (waddr),
		.we        (we),
		.sh        (sh),
		.ld        (ld),
		.init      (init),
		.init_data (init_data),
		.dout      (dout)
	);

	always #10 clk = ~clk;	// 20 ns period

	// bounds the whole run
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= max_cycles) begin
			$display("timeout, run still busy after %0d cycles", max_cycles);
			$display("ERRORS FOUND");
			$fatal(1, "watchdog expired");
		end
	end

	//////////////////////////////////////////////////////////////////////
	// helpers
	//////////////////////////////////////////////////////////////////////

	function automatic logic [`LIFE_ADDR_BITS-1:0] to_addr(input int a);
		return a[`LIFE_ADDR_BITS-1:0];
	endfunction

	task automatic wait_edges(input int n);
		for (int i = 0; i < n; i++) begin
			@(posedge clk);
		end
	endtask

	task automatic check_val(input string name, input img_row_t exp, input img_row_t act);
		if (exp !== act) begin
			$display("error %s expected %h actual %h", name, exp, act);
			$display("ERRORS FOUND");
			$fatal(1, "mismatch");
		end
	endtask

	// init write, lands at the edge after the drive
	task automatic write_row(input int addr, input img_row_t data);
		@(posedge clk);
		init      <= 1'b1;
		we        <= 1'b1;
		waddr     <= to_addr(addr);
		init_data <= data;
		@(posedge clk);
		init <= 1'b0;
		we   <= 1'b0;
	endtask

	task automatic load_image(input int base, input image_t img);
		for (int r = 0; r < img_rows; r++) begin
			write_row(base + r, img[r]);
		end
	endtask

	// ld sampled one edge after the drive, dout loads two edges later
	task automatic read_row(input int addr, output img_row_t data);
		@(posedge clk);
		ld    <= 1'b1;
		raddr <= to_addr(addr);
		@(posedge clk);
		ld <= 1'b0;
		wait_edges(2);
		@(negedge clk);		// dout stable here
		data = dout;
	endtask

	task automatic check_image(input int base, input image_t exp, input string name);
		img_row_t got;
		for (int r = 0; r < img_rows; r++) begin
			read_row(base + r, got);
			check_val($sformatf("%s row %0d", name, r), exp[r], got);
		end
	endtask

	// one pass src -> dst, each result written with the following strobe
	task automatic run_pass(input int src, input int dst, input bit irregular);
		int gap;
		int r;
		for (int p = 0; p < img_rows + 4 * gens; p++) begin
			@(posedge clk);
			sh    <= 1'b1;
			raddr <= to_addr(src + stream_row(p, gens));
			r = p - 1 - 4 * gens;	// row finished by the previous shift
			if (r >= 0 && r < img_rows) begin
				we    <= 1'b1;
				waddr <= to_addr(dst + r);
			end
			@(posedge clk);
			sh <= 1'b0;
			we <= 1'b0;
			gap = irregular ? 3 + int'($urandom % 6) : 3;	// 3..8 cycles
			wait_edges(gap - 2);
		end
		// last row has no following strobe
		wait_edges(1);
		@(posedge clk);
		we    <= 1'b1;
		waddr <= to_addr(dst + img_rows - 1);
		@(posedge clk);
		we <= 1'b0;
	endtask

	//////////////////////////////////////////////////////////////////////
	// test sequence
	//////////////////////////////////////////////////////////////////////

	initial begin
		image_t img;
		image_t pass_img;
		int     src;
		int     dst;
		int     pct;

		void'($urandom(seed));
		clk       = 1'b0;
		arst_n    = 1'b0;
		raddr     = '0;
		waddr     = '0;
		we        = 1'b0;
		sh        = 1'b0;
		ld        = 1'b0;
		init      = 1'b0;
		init_data = '0;
		cycles    = 0;
		wait_edges(5);
		arst_n <= 1'b1;
		@(negedge clk);
		check_val("reset dout", '0, dout);

		img = random_image(50);		// plain readback of half a
		load_image(half_a, img);
		check_image(half_a, img, "readback");

		pass_img = random_image(35);
		load_image(half_a, pass_img);
		run_pass(half_a, half_b, 1'b0);
		check_image(half_b, evolve(pass_img, gens), "one pass");

		img = edge_image();		// seams in both directions
		load_image(half_a, img);
		run_pass(half_a, half_b, 1'b0);
		check_image(half_b, evolve(img, gens), "edge wrap");

		// ping-pong between the halves
		for (int run = 0; run < 2; run++) begin
			pct = 15 + int'($urandom % 40);
			img = random_image(pct);
			load_image(half_a, img);
			for (int i = 0; i < passes; i++) begin
				src = (i % 2 == 0) ? half_a : half_b;
				dst = (i % 2 == 0) ? half_b : half_a;
				run_pass(src, dst, 1'b0);
				check_image(dst, evolve(img, gens * (i + 1)),
					$sformatf("multi pass %0d.%0d", run, i));
			end
		end

		load_image(half_a, pass_img);	// same image as the single pass
		run_pass(half_a, half_b, 1'b1);
		check_image(half_b, evolve(pass_img, gens), "irregular strobes");

		$display("NO ERRORS");
		$finish;
	end

endmodule
